// File: include/mem_addr_cfg.svh
/*
 * sizes and credit counts for the memory-address pipeline
 */
`ifndef MEM_ADDR_CFG_SVH
`define MEM_ADDR_CFG_SVH

// ====================
// datapath widths
// ====================
// address and operand width
`define ADDR_W 64
// instruction word width
`define INST_W 64
// tag carried with each instruction
`define TAG_W 4

// ====================
// flow control
// ====================
// issue buffer depth, equal to the source credits after reset
`define IN_CREDITS 4
// requests the memory port may hold
`define MEM_CREDITS 2
// width of the credit counters
`define CRED_W 3

`endif

// File: source/mem_addr_pkg.sv
/*
 * shared types of the memory-address pipeline
 * opcode, access size and fault cause enums
 */
package mem_addr_pkg;

	// ====================
	// opcodes
	// ====================
	// low two bits give the access size for every load and store
	// bit 2 selects the indexed form, bit 5 marks a store
	typedef enum logic [6:0] {
		LDB  = 7'h10,
		LDW  = 7'h11,
		LDT  = 7'h12,
		LDO  = 7'h13,
		LDBX = 7'h14,
		LDWX = 7'h15,
		LDTX = 7'h16,
		LDOX = 7'h17,
		POP  = 7'h18,
		STB  = 7'h20,
		STW  = 7'h21,
		STT  = 7'h22,
		STO  = 7'h23,
		STBX = 7'h24,
		STWX = 7'h25,
		STTX = 7'h26,
		STOX = 7'h27,
		PUSH = 7'h28
	} mem_op_e;

	// ====================
	// access size
	// ====================
	// encoding equals log2 of the size in bytes
	typedef enum logic [1:0] {
		SZ_B = 2'd0,
		SZ_W = 2'd1,
		SZ_T = 2'd2,
		SZ_O = 2'd3
	} acc_size_e;

	// fault causes reported instead of a memory request
	typedef enum logic {
		FAULT_ALIGN   = 1'b0,
		FAULT_ILLEGAL = 1'b1
	} fault_e;

endpackage

// File: source/mem_decode.sv
/*
 * stage 1 of the memory-address pipeline
 * splits the instruction word and registers the decoded fields
 */
`include "mem_addr_cfg.svh"

module mem_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic [`INST_W-1:0]      in_inst,
	input  logic [`ADDR_W-1:0]      in_a,
	input  logic [`ADDR_W-1:0]      in_c,
	input  logic [`TAG_W-1:0]       in_tag,
	output logic                    dec_valid,
	output mem_addr_pkg::mem_op_e   dec_op,
	output logic                    dec_illegal,
	output mem_addr_pkg::acc_size_e dec_size,
	output logic                    dec_store,
	output logic                    dec_scale,
	output logic [`ADDR_W-1:0]      dec_disp,
	output logic [1:0]              dec_push_cnt,
	output logic [`ADDR_W-1:0]      dec_a,
	output logic [`ADDR_W-1:0]      dec_c,
	output logic [`TAG_W-1:0]       dec_tag
);

	mem_addr_pkg::mem_op_e   op_raw;
	mem_addr_pkg::acc_size_e op_size;
	logic                    op_store;
	logic                    op_illegal;

	// opcode field in bits 6 to 0
	assign op_raw = mem_addr_pkg::mem_op_e'(in_inst[6:0]);

	// ====================
	// opcode lookup
	// ====================
	always_comb begin
		op_size    = mem_addr_pkg::SZ_B;
		op_store   = 1'b0;
		op_illegal = 1'b0;
		case (op_raw)
			mem_addr_pkg::LDB, mem_addr_pkg::LDBX: op_size = mem_addr_pkg::SZ_B;
			mem_addr_pkg::LDW, mem_addr_pkg::LDWX: op_size = mem_addr_pkg::SZ_W;
			mem_addr_pkg::LDT, mem_addr_pkg::LDTX: op_size = mem_addr_pkg::SZ_T;
			mem_addr_pkg::LDO, mem_addr_pkg::LDOX: op_size = mem_addr_pkg::SZ_O;
			mem_addr_pkg::POP: op_size = mem_addr_pkg::SZ_O;
			mem_addr_pkg::STB, mem_addr_pkg::STBX, mem_addr_pkg::STW, mem_addr_pkg::STWX,
			mem_addr_pkg::STT, mem_addr_pkg::STTX, mem_addr_pkg::STO, mem_addr_pkg::STOX: begin
				// store sizes follow the low two opcode bits
				op_size  = mem_addr_pkg::acc_size_e'(in_inst[1:0]);
				op_store = 1'b1;
			end
			mem_addr_pkg::PUSH: begin
				op_size  = mem_addr_pkg::SZ_O;
				op_store = 1'b1;
			end
			// anything outside the enum is dropped later as a fault
			default: op_illegal = 1'b1;
		endcase
	end

	// valid is the only control bit here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= in_valid;
		end
	end

	// payload fields
	always_ff @(posedge clk) begin
		dec_op       <= op_raw;
		dec_illegal  <= op_illegal;
		dec_size     <= op_size;
		dec_store    <= op_store;
		dec_scale    <= in_inst[28];
		// byte displacement in bits 22 to 8, sign extended
		dec_disp     <= {{(`ADDR_W-15){in_inst[22]}}, in_inst[22:8]};
		dec_push_cnt <= in_inst[35:34];
		dec_a        <= in_a;
		dec_c        <= in_c;
		dec_tag      <= in_tag;
	end

	// decoded opcode must be fully known when it is used downstream
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid |-> !$isunknown(dec_op));

endmodule

// File: source/agen.sv
/*
 * stage 2 of the memory-address pipeline
 * effective address from base, scaled index, displacement and stack forms
 */
`include "mem_addr_cfg.svh"

module agen (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    dec_valid,
	input  mem_addr_pkg::mem_op_e   dec_op,
	input  logic                    dec_illegal,
	input  mem_addr_pkg::acc_size_e dec_size,
	input  logic                    dec_store,
	input  logic                    dec_scale,
	input  logic [`ADDR_W-1:0]      dec_disp,
	input  logic [1:0]              dec_push_cnt,
	input  logic [`ADDR_W-1:0]      dec_a,
	input  logic [`ADDR_W-1:0]      dec_c,
	input  logic [`TAG_W-1:0]       dec_tag,
	output logic                    ag_valid,
	output logic [`ADDR_W-1:0]      ag_addr,
	output mem_addr_pkg::acc_size_e ag_size,
	output logic                    ag_store,
	output logic                    ag_illegal,
	output logic [`TAG_W-1:0]       ag_tag
);

	logic [1:0]         sc;
	logic [`ADDR_W-1:0] cx;
	logic [`ADDR_W-1:0] push_off;
	logic [`ADDR_W-1:0] ma;

	// ====================
	// index scaling
	// ====================
	// size encoding is already log2 of the byte count
	assign sc = dec_scale ? dec_size : 2'd0;
	assign cx = dec_c << sc;

	// push moves the stack down by eight bytes per count
	assign push_off = {{(`ADDR_W-5){1'b0}}, dec_push_cnt, 3'b000};

	// ====================
	// address forms
	// ====================
	always_comb begin
		case (dec_op)
			// base plus displacement
			mem_addr_pkg::LDB, mem_addr_pkg::LDW, mem_addr_pkg::LDT, mem_addr_pkg::LDO,
			mem_addr_pkg::STB, mem_addr_pkg::STW, mem_addr_pkg::STT, mem_addr_pkg::STO:
				ma = dec_a + dec_disp;
			// base plus index plus displacement
			mem_addr_pkg::LDBX, mem_addr_pkg::LDWX, mem_addr_pkg::LDTX, mem_addr_pkg::LDOX,
			mem_addr_pkg::STBX, mem_addr_pkg::STWX, mem_addr_pkg::STTX, mem_addr_pkg::STOX:
				ma = dec_a + cx + dec_disp;
			mem_addr_pkg::PUSH:
				ma = dec_a - push_off;
			// pop reads at the current stack pointer
			mem_addr_pkg::POP:
				ma = dec_a;
			// illegal ops never reach memory, address only goes to the fault port
			default:
				ma = dec_a + dec_disp;
		endcase
	end

	// ====================
	// stage register
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ag_valid <= 1'b0;
		end else begin
			ag_valid <= dec_valid;
		end
	end

	// address and attributes passed on to issue
	always_ff @(posedge clk) begin
		ag_addr    <= ma;
		ag_size    <= dec_size;
		ag_store   <= dec_store;
		ag_illegal <= dec_illegal;
		ag_tag     <= dec_tag;
	end

	// a pop leaves with the base it was decoded with
	a_pop_base: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid && dec_op == mem_addr_pkg::POP |=> ag_valid && ag_addr == $past(dec_a));

endmodule

// File: source/mem_issue.sv
/*
 * stage 3 of the memory-address pipeline
 * ordered issue buffer, alignment check, memory credits, request and fault ports
 */
`include "mem_addr_cfg.svh"

module mem_issue (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ag_valid,
	input  logic [`ADDR_W-1:0]        ag_addr,
	input  mem_addr_pkg::acc_size_e   ag_size,
	input  logic                      ag_store,
	input  logic                      ag_illegal,
	input  logic [`TAG_W-1:0]         ag_tag,
	input  logic                      mem_credit,
	output logic                      in_credit,
	output logic                      req_valid,
	output logic [`ADDR_W-1:0]        req_addr,
	output mem_addr_pkg::acc_size_e   req_size,
	output logic                      req_store,
	output logic [`TAG_W-1:0]         req_tag,
	output logic                      fault_valid,
	output logic [`ADDR_W-1:0]        fault_addr,
	output mem_addr_pkg::fault_e      fault_cause,
	output logic [`TAG_W-1:0]         fault_tag
);

	localparam int DEPTH    = `IN_CREDITS;
	localparam int PTR_W    = $clog2(`IN_CREDITS);
	localparam int LAST_PTR = DEPTH - 1;
	localparam int MCRED    = `MEM_CREDITS;

	// buffer storage, payload only
	logic [`ADDR_W-1:0]      q_addr    [DEPTH];
	mem_addr_pkg::acc_size_e q_size    [DEPTH];
	logic                    q_store   [DEPTH];
	logic                    q_illegal [DEPTH];
	logic [`TAG_W-1:0]       q_tag     [DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [`CRED_W-1:0] cnt;
	logic [`CRED_W-1:0] mcnt;

	logic                    head_valid;
	logic [`ADDR_W-1:0]      head_addr;
	mem_addr_pkg::acc_size_e head_size;
	logic                    head_store;
	logic                    head_illegal;
	logic [`TAG_W-1:0]       head_tag;
	logic [2:0]              align_mask;
	logic                    head_fault;
	logic                    depart;
	logic                    spend;
	logic                    bypass;
	logic                    wr_en;
	logic                    rd_en;

	// ====================
	// head selection
	// ====================
	// an empty buffer lets the incoming entry act as head
	assign head_valid   = (cnt != '0) || ag_valid;
	assign head_addr    = (cnt != '0) ? q_addr[rd_ptr]    : ag_addr;
	assign head_size    = (cnt != '0) ? q_size[rd_ptr]    : ag_size;
	assign head_store   = (cnt != '0) ? q_store[rd_ptr]   : ag_store;
	assign head_illegal = (cnt != '0) ? q_illegal[rd_ptr] : ag_illegal;
	assign head_tag     = (cnt != '0) ? q_tag[rd_ptr]     : ag_tag;

	// low address bits that must be zero for natural alignment
	always_comb begin
		case (head_size)
			mem_addr_pkg::SZ_W: align_mask = 3'b001;
			mem_addr_pkg::SZ_T: align_mask = 3'b011;
			mem_addr_pkg::SZ_O: align_mask = 3'b111;
			default:            align_mask = 3'b000;
		endcase
	end

	assign head_fault = head_illegal || ((head_addr[2:0] & align_mask) != 3'b000);
	// faults leave at once, requests wait for a memory credit
	assign depart     = head_valid && (head_fault || (mcnt != '0));
	assign spend      = depart && !head_fault;
	assign bypass     = (cnt == '0) && ag_valid && depart;
	assign wr_en      = ag_valid && !bypass;
	assign rd_en      = depart && (cnt != '0);

	// ====================
	// buffer control
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_PTR[PTR_W-1:0]) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST_PTR[PTR_W-1:0]) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			q_addr[wr_ptr]    <= ag_addr;
			q_size[wr_ptr]    <= ag_size;
			q_store[wr_ptr]   <= ag_store;
			q_illegal[wr_ptr] <= ag_illegal;
			q_tag[wr_ptr]     <= ag_tag;
		end
	end

	// memory credits, return and spend may coincide
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mcnt <= MCRED[`CRED_W-1:0];
		end else begin
			case ({mem_credit, spend})
				2'b10:   mcnt <= mcnt + 1'b1;
				2'b01:   mcnt <= mcnt - 1'b1;
				default: mcnt <= mcnt;
			endcase
		end
	end

	// ====================
	// output registers
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_valid   <= 1'b0;
			fault_valid <= 1'b0;
			in_credit   <= 1'b0;
		end else begin
			req_valid   <= spend;
			fault_valid <= depart && head_fault;
			// one source credit back per departure
			in_credit   <= depart;
		end
	end

	always_ff @(posedge clk) begin
		req_addr    <= head_addr;
		req_size    <= head_size;
		req_store   <= head_store;
		req_tag     <= head_tag;
		fault_addr  <= head_addr;
		// illegal opcode outranks misalignment
		fault_cause <= head_illegal ? mem_addr_pkg::FAULT_ILLEGAL : mem_addr_pkg::FAULT_ALIGN;
		fault_tag   <= head_tag;
	end

	// source credits keep the buffer from overflowing
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> cnt != DEPTH[`CRED_W-1:0]);
	// memory never returns more than it was given
	a_mcnt_max: assert property (@(posedge clk) disable iff (!rst_n)
		mcnt <= MCRED[`CRED_W-1:0]);
	a_req_credit: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> $past(mcnt) != '0);
	a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
		!(req_valid && fault_valid));

endmodule

// File: source/mem_addr_pipe.sv
/*
 * top level of the memory-address pipeline
 * decode, address generation and issue stages
 */
`include "mem_addr_cfg.svh"

module mem_addr_pipe (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic [`INST_W-1:0]      in_inst,
	input  logic [`ADDR_W-1:0]      in_a,
	input  logic [`ADDR_W-1:0]      in_c,
	input  logic [`TAG_W-1:0]       in_tag,
	input  logic                    mem_credit,
	output logic                    in_credit,
	output logic                    req_valid,
	output logic [`ADDR_W-1:0]      req_addr,
	output mem_addr_pkg::acc_size_e req_size,
	output logic                    req_store,
	output logic [`TAG_W-1:0]       req_tag,
	output logic                    fault_valid,
	output logic [`ADDR_W-1:0]      fault_addr,
	output mem_addr_pkg::fault_e    fault_cause,
	output logic [`TAG_W-1:0]       fault_tag
);

	// ====================
	// decode to agen
	// ====================
	logic                    dec_valid;
	mem_addr_pkg::mem_op_e   dec_op;
	logic                    dec_illegal;
	mem_addr_pkg::acc_size_e dec_size;
	logic                    dec_store;
	logic                    dec_scale;
	logic [`ADDR_W-1:0]      dec_disp;
	logic [1:0]              dec_push_cnt;
	logic [`ADDR_W-1:0]      dec_a;
	logic [`ADDR_W-1:0]      dec_c;
	logic [`TAG_W-1:0]       dec_tag;

	// agen to issue
	logic                    ag_valid;
	logic [`ADDR_W-1:0]      ag_addr;
	mem_addr_pkg::acc_size_e ag_size;
	logic                    ag_store;
	logic                    ag_illegal;
	logic [`TAG_W-1:0]       ag_tag;

	mem_decode i_mem_decode (
		.clk, .rst_n, .in_valid, .in_inst, .in_a, .in_c, .in_tag,
		.dec_valid, .dec_op, .dec_illegal, .dec_size, .dec_store, .dec_scale,
		.dec_disp, .dec_push_cnt, .dec_a, .dec_c, .dec_tag
	);

	agen i_agen (
		.clk, .rst_n,
		.dec_valid, .dec_op, .dec_illegal, .dec_size, .dec_store, .dec_scale,
		.dec_disp, .dec_push_cnt, .dec_a, .dec_c, .dec_tag,
		.ag_valid, .ag_addr, .ag_size, .ag_store, .ag_illegal, .ag_tag
	);

	// buffer and memory port
	mem_issue i_mem_issue (
		.clk, .rst_n,
		.ag_valid, .ag_addr, .ag_size, .ag_store, .ag_illegal, .ag_tag,
		.mem_credit, .in_credit,
		.req_valid, .req_addr, .req_size, .req_store, .req_tag,
		.fault_valid, .fault_addr, .fault_cause, .fault_tag
	);

endmodule

// File: tests/tb_mem_addr_pipe.sv
/*
 * testbench for the memory-address pipeline
 * source and memory credit models, reference address rule,
 * compare tasks, directed tests and watchdog
 */
`include "mem_addr_cfg.svh"

module tb_mem_addr_pipe;

	// test lengths in instructions, reset test in idle cycles
	localparam int TEST_LEN = 8 + 16 + 16 + 5 + 4 + 8;
	localparam int WATCHDOG = TEST_LEN * 20 * 10;

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	logic [`INST_W-1:0]      in_inst;
	logic [`ADDR_W-1:0]      in_a;
	logic [`ADDR_W-1:0]      in_c;
	logic [`TAG_W-1:0]       in_tag;
	logic                    mem_credit;
	logic                    in_credit;
	logic                    req_valid;
	logic [`ADDR_W-1:0]      req_addr;
	mem_addr_pkg::acc_size_e req_size;
	logic                    req_store;
	logic [`TAG_W-1:0]       req_tag;
	logic                    fault_valid;
	logic [`ADDR_W-1:0]      fault_addr;
	mem_addr_pkg::fault_e    fault_cause;
	logic [`TAG_W-1:0]       fault_tag;

	integer            seed = 32'h11c9_34b6;
	int                checks = 0;
	int                errors = 0;
	int                sent = 0;
	int                credits_back = 0;
	int                req_seen = 0;
	int                mem_returned = 0;
	int                cyc = 0;
	int                rd = 0;
	logic [`TAG_W-1:0] tag_ctr = '0;
	logic              mem_auto = 1'b1;
	logic              stream_sent = 1'b0;

	// expected and observed port events, in departure order
	logic                    e_fault[$], o_fault[$];
	logic [`ADDR_W-1:0]      e_addr[$], o_addr[$];
	mem_addr_pkg::acc_size_e e_size[$], o_size[$];
	logic                    e_store[$], o_store[$];
	logic [`TAG_W-1:0]       e_tag[$], o_tag[$];
	mem_addr_pkg::fault_e    e_cause[$], o_cause[$];
	int                      e_cyc[$], o_cyc[$];
	logic                    o_cred[$];

	mem_addr_pipe i_mem_addr_pipe (
		.clk, .rst_n, .in_valid, .in_inst, .in_a, .in_c, .in_tag, .mem_credit,
		.in_credit, .req_valid, .req_addr, .req_size, .req_store, .req_tag,
		.fault_valid, .fault_addr, .fault_cause, .fault_tag
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ====================
	// monitor and memory
	// ====================
	task automatic log_event(input logic f, input logic [`ADDR_W-1:0] addr,
		input mem_addr_pkg::acc_size_e sz, input logic st, input logic [`TAG_W-1:0] tag,
		input mem_addr_pkg::fault_e cause);
		o_fault.push_back(f);
		o_addr.push_back(addr);
		o_size.push_back(sz);
		o_store.push_back(st);
		o_tag.push_back(tag);
		o_cause.push_back(cause);
		o_cyc.push_back(cyc);
		// departures must return a source credit in the same cycle
		o_cred.push_back(in_credit);
	endtask

	// outputs are sampled at the falling edge, cycle count advances here
	always @(negedge clk) begin
		if (rst_n) begin
			if (req_valid) begin
				log_event(1'b0, req_addr, req_size, req_store, req_tag, mem_addr_pkg::FAULT_ALIGN);
				req_seen++;
			end
			if (fault_valid)
				log_event(1'b1, fault_addr, mem_addr_pkg::SZ_B, 1'b0, fault_tag, fault_cause);
			if (in_credit)
				credits_back++;
		end
		cyc++;
	end

	// memory hands back one credit per cycle while returns are enabled
	initial begin
		mem_credit = 1'b0;
		forever begin
			@(posedge clk);
			if (mem_auto && req_seen > mem_returned) begin
				mem_credit <= 1'b1;
				mem_returned++;
			end else begin
				mem_credit <= 1'b0;
			end
		end
	end

	// ====================
	// reference rule
	// ====================
	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// size by opcode name, store flag, and whether the opcode exists
	function automatic void op_info(input logic [6:0] op, output mem_addr_pkg::acc_size_e sz,
		output logic st, output logic ok);
		ok = 1'b1;
		case (op)
			mem_addr_pkg::LDB, mem_addr_pkg::LDBX, mem_addr_pkg::STB, mem_addr_pkg::STBX:
				sz = mem_addr_pkg::SZ_B;
			mem_addr_pkg::LDW, mem_addr_pkg::LDWX, mem_addr_pkg::STW, mem_addr_pkg::STWX:
				sz = mem_addr_pkg::SZ_W;
			mem_addr_pkg::LDT, mem_addr_pkg::LDTX, mem_addr_pkg::STT, mem_addr_pkg::STTX:
				sz = mem_addr_pkg::SZ_T;
			mem_addr_pkg::LDO, mem_addr_pkg::LDOX, mem_addr_pkg::STO, mem_addr_pkg::STOX,
			mem_addr_pkg::PUSH, mem_addr_pkg::POP:
				sz = mem_addr_pkg::SZ_O;
			default: begin
				sz = mem_addr_pkg::SZ_B;
				ok = 1'b0;
			end
		endcase
		case (op)
			mem_addr_pkg::STB, mem_addr_pkg::STW, mem_addr_pkg::STT, mem_addr_pkg::STO,
			mem_addr_pkg::STBX, mem_addr_pkg::STWX, mem_addr_pkg::STTX, mem_addr_pkg::STOX,
			mem_addr_pkg::PUSH:
				st = 1'b1;
			default:
				st = 1'b0;
		endcase
	endfunction

	function automatic int bytes_of(input mem_addr_pkg::acc_size_e sz);
		case (sz)
			mem_addr_pkg::SZ_W: return 2;
			mem_addr_pkg::SZ_T: return 4;
			mem_addr_pkg::SZ_O: return 8;
			default:            return 1;
		endcase
	endfunction

	// scaling the index by the size in bytes is the same as the log2 shift
	function automatic logic [`ADDR_W-1:0] ref_addr(input logic [6:0] op,
		input logic [`ADDR_W-1:0] a, input logic [`ADDR_W-1:0] c, input logic [14:0] d,
		input logic scale, input logic [1:0] pcnt, input mem_addr_pkg::acc_size_e sz);
		logic [`ADDR_W-1:0] dx;
		logic [`ADDR_W-1:0] cx;
		dx = {{(`ADDR_W-15){d[14]}}, d};
		cx = scale ? c * 64'(bytes_of(sz)) : c;
		case (op)
			mem_addr_pkg::PUSH: return a - 64'(pcnt) * 64'd8;
			mem_addr_pkg::POP:  return a;
			mem_addr_pkg::LDBX, mem_addr_pkg::LDWX, mem_addr_pkg::LDTX, mem_addr_pkg::LDOX,
			mem_addr_pkg::STBX, mem_addr_pkg::STWX, mem_addr_pkg::STTX, mem_addr_pkg::STOX:
				return a + cx + dx;
			default: return a + dx;
		endcase
	endfunction

	// unused instruction bits carry noise
	function automatic logic [`INST_W-1:0] build_inst(input logic [6:0] op,
		input logic [14:0] d, input logic scale, input logic [1:0] pcnt);
		logic [`INST_W-1:0] w;
		w = rand64();
		w[6:0] = op;
		w[22:8] = d;
		w[28] = scale;
		w[35:34] = pcnt;
		return w;
	endfunction

	// ====================
	// compare tasks
	// ====================
	task automatic show_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic compare_addr(input string name, input logic [`ADDR_W-1:0] got,
		input logic [`ADDR_W-1:0] exp);
		checks++;
		if (got !== exp)
			show_mismatch(name, got, exp);
	endtask

	task automatic compare_size(input string name, input mem_addr_pkg::acc_size_e got,
		input mem_addr_pkg::acc_size_e exp);
		checks++;
		if (got !== exp)
			show_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic compare_fault(input string name, input mem_addr_pkg::fault_e got,
		input mem_addr_pkg::fault_e exp);
		checks++;
		if (got !== exp)
			show_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic compare_tag(input string name, input logic [`TAG_W-1:0] got,
		input logic [`TAG_W-1:0] exp);
		checks++;
		if (got !== exp)
			show_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
			show_mismatch(name, 64'(got), 64'(exp));
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
			show_mismatch(name, 64'(got), 64'(exp));
	endtask

	// ====================
	// stimulus
	// ====================
	// waits for a source credit, then raises in_valid for one cycle
	task automatic send(input logic [6:0] op, input logic [`ADDR_W-1:0] a,
		input logic [`ADDR_W-1:0] c, input logic [14:0] d, input logic scale,
		input logic [1:0] pcnt, input logic timed);
		mem_addr_pkg::acc_size_e sz;
		logic                    st;
		logic                    ok;
		logic [`ADDR_W-1:0]      addr;
		op_info(op, sz, st, ok);
		addr = ref_addr(op, a, c, d, scale, pcnt, sz);
		// illegal opcode is checked before alignment
		e_fault.push_back(!ok || ((addr & 64'(bytes_of(sz) - 1)) != '0));
		e_addr.push_back(addr);
		e_size.push_back(sz);
		e_store.push_back(st);
		e_tag.push_back(tag_ctr);
		e_cause.push_back(ok ? mem_addr_pkg::FAULT_ALIGN : mem_addr_pkg::FAULT_ILLEGAL);
		@(posedge clk);
		while (`IN_CREDITS - sent + credits_back <= 0)
			@(posedge clk);
		e_cyc.push_back(timed ? cyc : -1);
		in_valid <= 1'b1;
		in_inst  <= build_inst(op, d, scale, pcnt);
		in_a     <= a;
		in_c     <= c;
		in_tag   <= tag_ctr;
		sent++;
		tag_ctr = tag_ctr + 1'b1;
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// compares every new event against the expected stream, in order
	task automatic check_stream();
		int n;
		n = e_tag.size();
		while (o_tag.size() < n)
			@(posedge clk);
		// a few idle cycles to catch extra events
		repeat (6) @(posedge clk);
		compare_count("event count", o_tag.size(), n);
		for (int i = rd; i < n; i++) begin
			compare_flag("fault_valid", o_fault[i], e_fault[i]);
			compare_tag("tag", o_tag[i], e_tag[i]);
			compare_flag("in_credit", o_cred[i], 1'b1);
			if (e_cyc[i] >= 0)
				compare_count("latency", o_cyc[i] - e_cyc[i], 3);
			if (e_fault[i] && o_fault[i]) begin
				compare_fault("fault_cause", o_cause[i], e_cause[i]);
				if (e_cause[i] == mem_addr_pkg::FAULT_ALIGN)
					compare_addr("fault_addr", o_addr[i], e_addr[i]);
			end else if (!e_fault[i] && !o_fault[i]) begin
				compare_addr("req_addr", o_addr[i], e_addr[i]);
				compare_size("req_size", o_size[i], e_size[i]);
				compare_flag("req_store", o_store[i], e_store[i]);
			end
		end
		rd = n;
	endtask

	task automatic test_done(input string name, input int e0);
		$display("%s finished with %0d errors", name, errors - e0);
	endtask

	// ====================
	// directed tests
	// ====================
	task automatic test_reset();
		int e0;
		e0 = errors;
		repeat (8) begin
			@(negedge clk);
			compare_flag("req_valid", req_valid, 1'b0);
			compare_flag("fault_valid", fault_valid, 1'b0);
			compare_flag("in_credit", in_credit, 1'b0);
		end
		test_done("reset state", e0);
	endtask

	// positive and negative displacements, all multiples of 8
	task automatic test_disp();
		logic [6:0]  ops[$];
		logic [14:0] d;
		int          e0;
		ops = '{mem_addr_pkg::LDB, mem_addr_pkg::LDW, mem_addr_pkg::LDT, mem_addr_pkg::LDO,
			mem_addr_pkg::STB, mem_addr_pkg::STW, mem_addr_pkg::STT, mem_addr_pkg::STO};
		e0 = errors;
		for (int i = 0; i < 16; i++) begin
			d = 15'($random(seed)) & 15'h3ff8;
			if (i % 2 == 1)
				d = -d;
			send(ops[i / 2], rand64() & ~64'h7, rand64(), d, 1'b0, 2'd0, 1'b1);
		end
		check_stream();
		test_done("displacement forms", e0);
	endtask

	task automatic test_index();
		logic [6:0] ops[$];
		int         e0;
		ops = '{mem_addr_pkg::LDBX, mem_addr_pkg::LDWX, mem_addr_pkg::LDTX, mem_addr_pkg::LDOX,
			mem_addr_pkg::STBX, mem_addr_pkg::STWX, mem_addr_pkg::STTX, mem_addr_pkg::STOX};
		e0 = errors;
		for (int i = 0; i < 16; i++)
			send(ops[i / 2], rand64() & ~64'h7, rand64() & ~64'h7,
				15'($random(seed)) & 15'h7ff8, (i % 2 == 1), 2'd0, 1'b1);
		check_stream();
		test_done("indexed forms", e0);
	endtask

	// the displacement field is noise for push and pop
	task automatic test_stack();
		int e0;
		e0 = errors;
		for (int p = 0; p < 4; p++)
			send(mem_addr_pkg::PUSH, rand64() & ~64'h7, rand64(), 15'($random(seed)),
				1'b0, 2'(p), 1'b1);
		send(mem_addr_pkg::POP, rand64() & ~64'h7, rand64(), 15'($random(seed)),
			1'b0, 2'd3, 1'b1);
		check_stream();
		test_done("push and pop", e0);
	endtask

	task automatic test_fault();
		int e0;
		e0 = errors;
		send(mem_addr_pkg::LDW, (rand64() & ~64'h7) | 64'h1, rand64(), 15'd0, 1'b0, 2'd0, 1'b1);
		send(mem_addr_pkg::LDT, (rand64() & ~64'h7) | 64'h2, rand64(), 15'd0, 1'b0, 2'd0, 1'b1);
		send(mem_addr_pkg::STO, (rand64() & ~64'h7) | 64'h4, rand64(), 15'd0, 1'b0, 2'd0, 1'b1);
		// opcode outside the enum
		send(7'h7f, rand64(), rand64(), 15'($random(seed)), 1'b0, 2'd0, 1'b1);
		check_stream();
		test_done("faults", e0);
	endtask

	// memory credits withheld, a misaligned load sits in the middle
	task automatic test_backpressure();
		logic [6:0] ops[$];
		int         e0;
		int         s0;
		int         c0;
		ops = '{mem_addr_pkg::LDO, mem_addr_pkg::STW, mem_addr_pkg::LDB, mem_addr_pkg::STT,
			mem_addr_pkg::LDT, mem_addr_pkg::LDW, mem_addr_pkg::STO, mem_addr_pkg::STB};
		e0 = errors;
		s0 = sent;
		c0 = credits_back;
		mem_auto <= 1'b0;
		stream_sent = 1'b0;
		fork
			begin
				logic [`ADDR_W-1:0] a;
				for (int i = 0; i < 8; i++) begin
					a = rand64() & ~64'h7;
					if (i == 5)
						a = a | 64'h1;
					send(ops[i], a, rand64(), 15'($random(seed)) & 15'h7ff8, 1'b0, 2'd0, 1'b0);
				end
				stream_sent = 1'b1;
			end
		join_none
		repeat (40) @(posedge clk);
		// only the first requests got out, the buffer is full
		compare_count("events while blocked", o_tag.size() - rd, `MEM_CREDITS);
		compare_count("source credits held", `IN_CREDITS - sent + credits_back, 0);
		compare_count("instructions sent", sent - s0, `IN_CREDITS + `MEM_CREDITS);
		mem_auto <= 1'b1;
		while (!stream_sent)
			@(posedge clk);
		check_stream();
		compare_count("in_credit pulses", credits_back - c0, sent - s0);
		test_done("credit back-pressure", e0);
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_inst  = '0;
		in_a     = '0;
		in_c     = '0;
		in_tag   = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_disp();
		test_index();
		test_stack();
		test_fault();
		test_backpressure();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// ends a run that stalls, e.g. on a lost request or credit
	initial begin
		#(WATCHDOG);
		$display("timeout: the tests did not finish in time");
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: all.f
+incdir+include
source/mem_addr_pkg.sv
source/mem_decode.sv
source/agen.sv
source/mem_issue.sv
source/mem_addr_pipe.sv
tests/tb_mem_addr_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# build the memory-address pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f all.f \
	--top-module tb_mem_addr_pipe

out=$(./obj_dir/Vtb_mem_addr_pipe)
printf '%s\n' "$out"

# the run passes only if the testbench printed its pass line
if grep -qx "Done: no errors" <<< "$out"; then
	exit 0
else
	exit 1
fi
